/* rtl/imgproc_pkg.sv */
package imgproc_pkg;

	localparam int COORD_W = 11;
	localparam int PIX_W   = 24;
	localparam int DATA_W  = 32;

	typedef logic [COORD_W-1:0] coord_t;

	// Stream word seen as a pixel
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Stream word seen as the sop packet descriptor
	typedef struct packed {
		logic [19:0] reserved;
		logic [3:0]  packet_type;
	} desc_t;

	typedef union packed {
		rgb_t  rgb;
		desc_t desc;
	} pixel_word_u;

	localparam logic [3:0]        PACKET_VIDEO   = 4'h0;
	localparam logic [DATA_W-1:0] MSG_ID         = {16'h0, "NB"};
	localparam logic [DATA_W-1:0] DEVICE_ID      = 32'h1234EEE2;
	localparam logic [PIX_W-1:0]  BB_COL_DEFAULT = 24'h00ff00;

	// Register map
	localparam logic [2:0] ADDR_STATUS = 3'd0;
	localparam logic [2:0] ADDR_MSG    = 3'd1;
	localparam logic [2:0] ADDR_ID     = 3'd2;
	localparam logic [2:0] ADDR_BBCOL  = 3'd3;
	localparam int         FLUSH_BIT   = 4;    // Status write strobe, reads as 0

endpackage

/* rtl/stream_reg.sv */
`timescale 1ns/1ps

module stream_reg (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     valid_in,
	input  imgproc_pkg::pixel_word_u data_in,
	input  logic                     sop_in,
	input  logic                     eop_in,
	output logic                     ready_out,
	output logic                     valid_out,
	output imgproc_pkg::pixel_word_u data_out,
	output logic                     sop_out,
	output logic                     eop_out,
	input  logic                     ready_in
);

	logic [imgproc_pkg::PIX_W+1:0] payload;    // Word, sop, eop

	// Take a new word when empty or when the held one leaves this cycle
	assign ready_out = ~valid_out | ready_in;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
		end else if (ready_out) begin
			valid_out <= valid_in;
		end
	end

	// Payload only moves on an accepted transfer, so it holds under stall
	always_ff @(posedge clk) begin
		if (ready_out && valid_in) begin
			payload <= {data_in, sop_in, eop_in};
		end
	end

	assign data_out = payload[imgproc_pkg::PIX_W+1:2];
	assign sop_out  = payload[1];
	assign eop_out  = payload[0];

endmodule

/* rtl/frame_scanner.sv */
`timescale 1ns/1ps

module frame_scanner #(
	parameter int IMAGE_W = 640,
	parameter int IMAGE_H = 480
) (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     in_valid,
	input  logic                     out_ready,
	input  logic                     in_sop,
	input  logic                     in_eop,
	input  imgproc_pkg::pixel_word_u in_word,
	input  logic                     target,
	output imgproc_pkg::coord_t      x,
	output imgproc_pkg::coord_t      y,
	output logic                     video,
	output imgproc_pkg::coord_t      box_left,
	output imgproc_pkg::coord_t      box_right,
	output imgproc_pkg::coord_t      box_top,
	output imgproc_pkg::coord_t      box_bottom,
	output logic                     frame_done
);

	localparam imgproc_pkg::coord_t X_LAST = imgproc_pkg::coord_t'(IMAGE_W - 1);
	localparam imgproc_pkg::coord_t Y_LAST = imgproc_pkg::coord_t'(IMAGE_H - 1);

	logic                xfer;
	logic                hit;
	imgproc_pkg::coord_t min_x;
	imgproc_pkg::coord_t max_x;
	imgproc_pkg::coord_t min_y;
	imgproc_pkg::coord_t max_y;
	imgproc_pkg::coord_t nxt_min_x;
	imgproc_pkg::coord_t nxt_max_x;
	imgproc_pkg::coord_t nxt_min_y;
	imgproc_pkg::coord_t nxt_max_y;

	assign xfer = in_valid & out_ready;
	assign hit  = xfer & ~in_sop & video & target;

	// Running box with the current word folded in
	assign nxt_min_x = (hit && x < min_x) ? x : min_x;
	assign nxt_max_x = (hit && x > max_x) ? x : max_x;
	assign nxt_min_y = (hit && y < min_y) ? y : min_y;
	assign nxt_max_y = (hit && y > max_y) ? y : max_y;

	always_ff @(posedge clk) begin
		if (!reset_n || (xfer && in_sop)) begin
			x     <= '0;
			y     <= '0;
			min_x <= X_LAST;    // Empty box: min above max
			max_x <= '0;
			min_y <= Y_LAST;
			max_y <= '0;
			video <= reset_n && (in_word.desc.packet_type == imgproc_pkg::PACKET_VIDEO);
		end else if (xfer) begin
			if (x == X_LAST) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
			min_x <= nxt_min_x;
			max_x <= nxt_max_x;
			min_y <= nxt_min_y;
			max_y <= nxt_max_y;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// End of frame latch, eop pixel included

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			box_left   <= '0;
			box_right  <= '0;
			box_top    <= '0;
			box_bottom <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (xfer && in_eop && !in_sop && video) begin    // Non-video packets ignored
				box_left   <= nxt_min_x;
				box_right  <= nxt_max_x;
				box_top    <= nxt_min_y;
				box_bottom <= nxt_max_y;
				frame_done <= 1'b1;
			end
		end
	end

endmodule

/* rtl/pixel_overlay.sv */
`timescale 1ns/1ps

module pixel_overlay (
	input  imgproc_pkg::pixel_word_u       in_word,
	input  logic                           in_sop,
	input  logic                           video,
	input  logic                           mode,
	input  imgproc_pkg::coord_t            x,
	input  imgproc_pkg::coord_t            y,
	input  imgproc_pkg::coord_t            box_left,
	input  imgproc_pkg::coord_t            box_right,
	input  imgproc_pkg::coord_t            box_top,
	input  imgproc_pkg::coord_t            box_bottom,
	input  logic [imgproc_pkg::PIX_W-1:0]  bb_col,
	output imgproc_pkg::pixel_word_u       out_word,
	output logic                           target
);

	logic [7:0] grey;
	logic       on_edge;

	// Grey = green/2 + red/4 + blue/4, tops out at 253
	assign grey = {1'b0, in_word.rgb.green[7:1]} + {2'b0, in_word.rgb.red[7:2]}
		+ {2'b0, in_word.rgb.blue[7:2]};

	assign target = in_word.rgb.red[7] & in_word.rgb.green[7] & in_word.rgb.blue[7];

	// Box from the previous video frame
	assign on_edge = (x == box_left) | (x == box_right) | (y == box_top) | (y == box_bottom);

	always_comb begin
		out_word = in_word;    // Descriptors and non-video data pass through
		if (mode && video && !in_sop) begin
			if (on_edge) begin
				out_word = bb_col;
			end else if (target) begin
				out_word = 24'hffffff;
			end else begin
				out_word = {grey, grey, grey};
			end
		end
	end

endmodule

/* rtl/msg_writer.sv */
`timescale 1ns/1ps

module msg_writer #(
	parameter int MSG_INTERVAL  = 30,
	parameter int MSG_BUF_DEPTH = 2048
) (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              frame_done,
	input  imgproc_pkg::coord_t               box_left,
	input  imgproc_pkg::coord_t               box_right,
	input  imgproc_pkg::coord_t               box_top,
	input  imgproc_pkg::coord_t               box_bottom,
	input  logic [$clog2(MSG_BUF_DEPTH):0]    msg_used,
	output logic                              msg_wr,
	output logic [imgproc_pkg::DATA_W-1:0]    msg_data
);

	localparam int CNT_W = $clog2(MSG_INTERVAL) + 1;
	localparam int HALF  = imgproc_pkg::DATA_W / 2;
	localparam int ROOM  = MSG_BUF_DEPTH - 3;

	// Sequencer states
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_ID   = 2'd1;
	localparam logic [1:0] S_MIN  = 2'd2;
	localparam logic [1:0] S_MAX  = 2'd3;

	logic [1:0]                     state;
	logic [CNT_W-1:0]               frame_cnt;
	logic [imgproc_pkg::DATA_W-1:0] min_corner;
	logic [imgproc_pkg::DATA_W-1:0] max_corner;
	logic                           start;

	assign start = frame_done && (frame_cnt == '0) && (msg_used < ROOM);

	// A full FIFO leaves the count at 0, so the next frame retries
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= '0;
		end else if (start) begin
			frame_cnt <= CNT_W'(MSG_INTERVAL - 1);
		end else if (frame_done && frame_cnt != '0) begin
			frame_cnt <= frame_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE:  state <= start ? S_ID : S_IDLE;
				S_ID:    state <= S_MIN;
				S_MIN:   state <= S_MAX;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Corners are x high, y low; left above right means no target seen
	always_ff @(posedge clk) begin
		if (start) begin
			min_corner <= (box_left > box_right) ? '0 : {HALF'(box_left), HALF'(box_top)};
			max_corner <= {HALF'(box_right), HALF'(box_bottom)};
		end
	end

	assign msg_wr = (state != S_IDLE);

	always_comb begin
		case (state)
			S_ID:    msg_data = imgproc_pkg::MSG_ID;
			S_MIN:   msg_data = min_corner;
			S_MAX:   msg_data = max_corner;
			default: msg_data = '0;
		endcase
	end

endmodule

/* rtl/msg_fifo.sv */
`timescale 1ns/1ps

module msg_fifo #(
	parameter int MSG_BUF_DEPTH = 2048
) (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              clear,
	input  logic                              wr,
	input  logic [imgproc_pkg::DATA_W-1:0]    wr_data,
	input  logic                              rd,
	output logic [imgproc_pkg::DATA_W-1:0]    rd_data,
	output logic [$clog2(MSG_BUF_DEPTH):0]    used,
	output logic                              empty
);

	localparam int AW = $clog2(MSG_BUF_DEPTH);
	localparam int UW = AW + 1;

	logic [imgproc_pkg::DATA_W-1:0] mem [MSG_BUF_DEPTH];
	logic [AW-1:0]                  wr_ptr;
	logic [AW-1:0]                  rd_ptr;
	logic                           full;
	logic                           do_wr;
	logic                           do_rd;

	assign full  = used[AW];    // Depth is a power of two
	assign empty = (used == '0);
	assign do_wr = wr & ~full;  // Writes to a full FIFO are dropped
	assign do_rd = rd & ~empty;

	// Show-ahead: head word is always on rd_data
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			used <= used + UW'(do_wr) - UW'(do_rd);
		end
	end

endmodule

/* rtl/reg_port.sv */
`timescale 1ns/1ps

module reg_port #(
	parameter int MSG_BUF_DEPTH = 2048
) (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              s_chipselect,
	input  logic                              s_read,
	input  logic                              s_write,
	input  logic [2:0]                        s_address,
	input  logic [imgproc_pkg::DATA_W-1:0]    s_writedata,
	input  logic [imgproc_pkg::DATA_W-1:0]    msg_data,
	input  logic [$clog2(MSG_BUF_DEPTH):0]    msg_used,
	input  logic                              msg_empty,
	output logic [imgproc_pkg::DATA_W-1:0]    s_readdata,
	output logic [imgproc_pkg::PIX_W-1:0]     bb_col,
	output logic                              msg_rd,
	output logic                              msg_flush
);

	logic [7:0] reg_status;
	logic [7:0] used_byte;
	logic       wr_en;
	logic       rd_en;
	logic       read_d;    // Read strobe one cycle back

	assign wr_en     = s_chipselect & s_write;
	assign rd_en     = s_chipselect & s_read;
	assign used_byte = 8'(msg_used);

	assign msg_flush = wr_en && (s_address == imgproc_pkg::ADDR_STATUS)
		&& s_writedata[imgproc_pkg::FLUSH_BIT];

	// Pop on the leading cycle of the read only
	assign msg_rd = rd_en && !read_d && !msg_empty && (s_address == imgproc_pkg::ADDR_MSG);

	////////////////////////////////////////////////////////////////////////////
	// Writes

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reg_status <= '0;
			bb_col     <= imgproc_pkg::BB_COL_DEFAULT;
		end else if (wr_en) begin
			if (s_address == imgproc_pkg::ADDR_STATUS) begin
				reg_status <= s_writedata[7:0] & ~(8'h1 << imgproc_pkg::FLUSH_BIT);
			end
			if (s_address == imgproc_pkg::ADDR_BBCOL) begin
				bb_col <= s_writedata[imgproc_pkg::PIX_W-1:0];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reads, data one cycle after the strobe

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			s_readdata <= '0;
			read_d     <= 1'b0;
		end else begin
			read_d <= rd_en;
			if (rd_en) begin
				case (s_address)
					imgproc_pkg::ADDR_STATUS: s_readdata <= {16'h0, used_byte, reg_status};
					imgproc_pkg::ADDR_MSG:    s_readdata <= msg_empty ? '0 : msg_data;
					imgproc_pkg::ADDR_ID:     s_readdata <= imgproc_pkg::DEVICE_ID;
					imgproc_pkg::ADDR_BBCOL:  s_readdata <= {8'h0, bb_col};
					default:                  s_readdata <= '0;
				endcase
			end
		end
	end

endmodule

/* rtl/eee_imgproc.sv */
`timescale 1ns/1ps

module eee_imgproc #(
	parameter int IMAGE_W       = 640,
	parameter int IMAGE_H       = 480,
	parameter int MSG_INTERVAL  = 30,
	parameter int MSG_BUF_DEPTH = 2048
) (
	input  logic                              clk,
	input  logic                              reset_n,
	// CPU register port
	input  logic                              s_chipselect,
	input  logic                              s_read,
	input  logic                              s_write,
	output logic [imgproc_pkg::DATA_W-1:0]    s_readdata,
	input  logic [imgproc_pkg::DATA_W-1:0]    s_writedata,
	input  logic [2:0]                        s_address,
	// Stream in
	input  logic [imgproc_pkg::PIX_W-1:0]     sink_data,
	input  logic                              sink_valid,
	output logic                              sink_ready,
	input  logic                              sink_sop,
	input  logic                              sink_eop,
	// Stream out
	output logic [imgproc_pkg::PIX_W-1:0]     source_data,
	output logic                              source_valid,
	input  logic                              source_ready,
	output logic                              source_sop,
	output logic                              source_eop,
	input  logic                              mode
);

	localparam int USED_W = $clog2(MSG_BUF_DEPTH) + 1;

	imgproc_pkg::pixel_word_u       in_word;
	imgproc_pkg::pixel_word_u       out_word;
	logic                           in_sop;
	logic                           in_eop;
	logic                           in_valid;
	logic                           out_ready;
	logic                           target;
	logic                           video;
	logic                           frame_done;
	imgproc_pkg::coord_t            x;
	imgproc_pkg::coord_t            y;
	imgproc_pkg::coord_t            box_left;
	imgproc_pkg::coord_t            box_right;
	imgproc_pkg::coord_t            box_top;
	imgproc_pkg::coord_t            box_bottom;
	logic [imgproc_pkg::PIX_W-1:0]  bb_col;
	logic                           msg_wr;
	logic                           msg_rd;
	logic                           msg_flush;
	logic                           msg_empty;
	logic [imgproc_pkg::DATA_W-1:0] msg_wr_data;
	logic [imgproc_pkg::DATA_W-1:0] msg_head;
	logic [USED_W-1:0]              msg_used;

	////////////////////////////////////////////////////////////////////////////
	// Stream pipeline

	stream_reg in_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.valid_in  (sink_valid),
		.data_in   (sink_data),
		.sop_in    (sink_sop),
		.eop_in    (sink_eop),
		.ready_out (sink_ready),
		.valid_out (in_valid),
		.data_out  (in_word),
		.sop_out   (in_sop),
		.eop_out   (in_eop),
		.ready_in  (out_ready)
	);

	frame_scanner #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H)) i_scanner (
		.clk        (clk),
		.reset_n    (reset_n),
		.in_valid   (in_valid),
		.out_ready  (out_ready),
		.in_sop     (in_sop),
		.in_eop     (in_eop),
		.in_word    (in_word),
		.target     (target),
		.x          (x),
		.y          (y),
		.video      (video),
		.box_left   (box_left),
		.box_right  (box_right),
		.box_top    (box_top),
		.box_bottom (box_bottom),
		.frame_done (frame_done)
	);

	pixel_overlay i_overlay (
		.in_word    (in_word),
		.in_sop     (in_sop),
		.video      (video),
		.mode       (mode),
		.x          (x),
		.y          (y),
		.box_left   (box_left),
		.box_right  (box_right),
		.box_top    (box_top),
		.box_bottom (box_bottom),
		.bb_col     (bb_col),
		.out_word   (out_word),
		.target     (target)
	);

	stream_reg out_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.valid_in  (in_valid),
		.data_in   (out_word),
		.sop_in    (in_sop),
		.eop_in    (in_eop),
		.ready_out (out_ready),
		.valid_out (source_valid),
		.data_out  (source_data),
		.sop_out   (source_sop),
		.eop_out   (source_eop),
		.ready_in  (source_ready)
	);

	////////////////////////////////////////////////////////////////////////////
	// Messages and registers

	msg_writer #(.MSG_INTERVAL(MSG_INTERVAL), .MSG_BUF_DEPTH(MSG_BUF_DEPTH)) i_writer (
		.clk        (clk),
		.reset_n    (reset_n),
		.frame_done (frame_done),
		.box_left   (box_left),
		.box_right  (box_right),
		.box_top    (box_top),
		.box_bottom (box_bottom),
		.msg_used   (msg_used),
		.msg_wr     (msg_wr),
		.msg_data   (msg_wr_data)
	);

	msg_fifo #(.MSG_BUF_DEPTH(MSG_BUF_DEPTH)) i_fifo (
		.clk     (clk),
		.reset_n (reset_n),
		.clear   (msg_flush),
		.wr      (msg_wr),
		.wr_data (msg_wr_data),
		.rd      (msg_rd),
		.rd_data (msg_head),
		.used    (msg_used),
		.empty   (msg_empty)
	);

	reg_port #(.MSG_BUF_DEPTH(MSG_BUF_DEPTH)) i_regs (
		.clk          (clk),
		.reset_n      (reset_n),
		.s_chipselect (s_chipselect),
		.s_read       (s_read),
		.s_write      (s_write),
		.s_address    (s_address),
		.s_writedata  (s_writedata),
		.msg_data     (msg_head),
		.msg_used     (msg_used),
		.msg_empty    (msg_empty),
		.s_readdata   (s_readdata),
		.bb_col       (bb_col),
		.msg_rd       (msg_rd),
		.msg_flush    (msg_flush)
	);

endmodule

/* sim/imgproc_properties.sv */
`timescale 1ns/1ps

module imgproc_properties #(
	parameter int MSG_BUF_DEPTH = 2048
) (
	input  logic                           clk,
	input  logic                           reset_n,
	input  logic                           source_valid,
	input  logic                           source_ready,
	input  logic [23:0]                    source_data,
	input  logic                           source_sop,
	input  logic                           source_eop,
	input  logic [$clog2(MSG_BUF_DEPTH):0] msg_used
);

	// Stalled word stays offered and unchanged
	hold_under_stall: assert property (@(posedge clk) disable iff (!reset_n)
		source_valid && !source_ready
		|=> source_valid && $stable({source_data, source_sop, source_eop}))
		else $error("source word changed or vanished while stalled");

	idle_after_reset: assert property (@(posedge clk) !reset_n |=> !source_valid)
		else $error("source_valid high right after reset");

	fifo_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		msg_used <= MSG_BUF_DEPTH)
		else $error("message FIFO count above its depth");

endmodule

/* sim/imgproc_checker.sv */
`timescale 1ns/1ps

module imgproc_checker #(
	parameter int IMAGE_W       = 640,
	parameter int IMAGE_H       = 480,
	parameter int MSG_INTERVAL  = 30,
	parameter int MSG_BUF_DEPTH = 2048
) (
	input  logic        clk,
	input  logic        reset_n,
	input  logic [23:0] sink_data,
	input  logic        sink_valid,
	input  logic        sink_ready,
	input  logic        sink_sop,
	input  logic        sink_eop,
	input  logic [23:0] source_data,
	input  logic        source_valid,
	input  logic        source_ready,
	input  logic        source_sop,
	input  logic        source_eop,
	input  logic        mode,
	input  logic        s_chipselect,
	input  logic        s_read,
	input  logic        s_write,
	input  logic [2:0]  s_address,
	input  logic [31:0] s_writedata,
	input  logic [31:0] s_readdata,
	output int          error_count,
	output int          word_count,
	output int          read_count,
	output int          pending
);

	logic [25:0] expect_q[$];    // Word, sop, eop
	logic [31:0] msg_q[$];
	logic [25:0] exp_w;
	logic [23:0] col;
	logic [7:0]  status_byte;
	logic        video;
	logic        rd_pending;
	logic        rd_prev;
	logic [31:0] rd_expect;
	int          x;
	int          y;
	int          min_x;
	int          max_x;
	int          min_y;
	int          max_y;
	int          hits;
	int          box_l;
	int          box_r;
	int          box_t;
	int          box_b;
	int          frame_cnt;
	int          errors = 0;
	int          words = 0;
	int          reads = 0;

	assign error_count = errors;
	assign word_count  = words;
	assign read_count  = reads;
	assign pending     = expect_q.size();

	////////////////////////////////////////////////////////////////////////////
	// Stream model

	function automatic logic [23:0] predict_pixel(input logic [23:0] w);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic [7:0] grey;
		r    = w[23:16];
		g    = w[15:8];
		b    = w[7:0];
		grey = 8'(g / 2) + 8'(r / 4) + 8'(b / 4);
		if (!mode || !video) begin
			return w;
		end else if (x == box_l || x == box_r || y == box_t || y == box_b) begin
			return col;
		end else if (r[7] && g[7] && b[7]) begin
			return 24'hffffff;
		end
		return {grey, grey, grey};
	endfunction

	// Box is published and the message counter steps at each video frame end
	task automatic close_frame();
		box_l = min_x;
		box_r = max_x;
		box_t = min_y;
		box_b = max_y;
		if (frame_cnt == 0 && msg_q.size() < MSG_BUF_DEPTH - 3) begin
			msg_q.push_back(imgproc_pkg::MSG_ID);
			msg_q.push_back(hits == 0 ? 32'h0 : {16'(min_x), 16'(min_y)});
			msg_q.push_back({16'(max_x), 16'(max_y)});
			frame_cnt = MSG_INTERVAL - 1;
		end else if (frame_cnt != 0) begin
			frame_cnt--;
		end
	endtask

	task automatic accept_sink_word();
		logic target;
		target = sink_data[23] & sink_data[15] & sink_data[7];
		if (sink_sop) begin
			expect_q.push_back({sink_data, 1'b1, sink_eop});
			video = sink_data[3:0] == imgproc_pkg::PACKET_VIDEO;
			x     = 0;
			y     = 0;
			min_x = IMAGE_W - 1;
			max_x = 0;
			min_y = IMAGE_H - 1;
			max_y = 0;
			hits  = 0;
		end else begin
			expect_q.push_back({predict_pixel(sink_data), 1'b0, sink_eop});
			if (video && target) begin
				min_x = (x < min_x) ? x : min_x;
				max_x = (x > max_x) ? x : max_x;
				min_y = (y < min_y) ? y : min_y;
				max_y = (y > max_y) ? y : max_y;
				hits++;
			end
			if (video && sink_eop) begin
				close_frame();
			end
			if (x == IMAGE_W - 1) begin
				x = 0;
				y++;
			end else begin
				x++;
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Register model, read data due one cycle after the strobe

	task automatic check_bus();
		if (rd_pending) begin
			reads++;
			if (s_readdata !== rd_expect) begin
				errors++;
				$display("error at %0t: register read returned %h, expected %h",
					$time, s_readdata, rd_expect);
			end
		end
		rd_pending = 1'b0;
		if (s_chipselect && s_read) begin
			case (s_address)
				imgproc_pkg::ADDR_STATUS: rd_expect = {16'h0, 8'(msg_q.size()), status_byte};
				imgproc_pkg::ADDR_MSG:    rd_expect = (msg_q.size() == 0) ? 32'h0 : msg_q[0];
				imgproc_pkg::ADDR_ID:     rd_expect = imgproc_pkg::DEVICE_ID;
				imgproc_pkg::ADDR_BBCOL:  rd_expect = {8'h0, col};
				default:                  rd_expect = 32'h0;
			endcase
			if (s_address == imgproc_pkg::ADDR_MSG && !rd_prev && msg_q.size() != 0) begin
				void'(msg_q.pop_front());
			end
			rd_pending = 1'b1;
		end
		rd_prev = s_chipselect && s_read;
		if (s_chipselect && s_write && s_address == imgproc_pkg::ADDR_STATUS) begin
			status_byte = s_writedata[7:0] & 8'hef;
			if (s_writedata[4]) begin
				msg_q.delete();
			end
		end
		if (s_chipselect && s_write && s_address == imgproc_pkg::ADDR_BBCOL) begin
			col = s_writedata[23:0];
		end
	endtask

	// Falling edge, everything settled from the last rising edge
	always @(negedge clk) begin
		if (!reset_n) begin
			expect_q.delete();
			msg_q.delete();
			col         = imgproc_pkg::BB_COL_DEFAULT;
			status_byte = '0;
			video       = 1'b0;
			rd_pending  = 1'b0;
			rd_prev     = 1'b0;
			box_l       = 0;
			box_r       = 0;
			box_t       = 0;
			box_b       = 0;
			frame_cnt   = 0;
		end else begin
			if (source_valid && source_ready) begin
				if (expect_q.size() == 0) begin
					errors++;
					$display("error at %0t: source sent word %h with none expected",
						$time, source_data);
				end else begin
					exp_w = expect_q.pop_front();
					words++;
					if ({source_data, source_sop, source_eop} !== exp_w) begin
						errors++;
						$display("error at %0t: source word %0d is %h sop %b eop %b, expected %h",
							$time, words, source_data, source_sop, source_eop, exp_w);
					end
				end
			end
			if (sink_valid && sink_ready) begin
				accept_sink_word();
			end
			check_bus();
		end
	end

endmodule

/* sim/tb_imgproc.sv */
`timescale 1ns/1ps

module tb_imgproc;

	localparam int IMAGE_W       = 16;
	localparam int IMAGE_H       = 8;
	localparam int MSG_INTERVAL  = 2;
	localparam int MSG_BUF_DEPTH = 16;
	localparam int NUM_FRAMES    = 12;
	localparam int FRAME_CYCLES  = (IMAGE_W * IMAGE_H + 1) * 4;
	localparam int EXTRA_CYCLES  = 150;    // Register phase and odd packet per frame
	localparam int TIMEOUT_NS    = (NUM_FRAMES * (FRAME_CYCLES + EXTRA_CYCLES) + 50) * 10;

	logic        clk;
	logic        reset_n;
	logic        s_chipselect;
	logic        s_read;
	logic        s_write;
	logic [31:0] s_readdata;
	logic [31:0] s_writedata;
	logic [2:0]  s_address;
	logic [23:0] sink_data;
	logic        sink_valid;
	logic        sink_ready;
	logic        sink_sop;
	logic        sink_eop;
	logic [23:0] source_data;
	logic        source_valid;
	logic        source_ready;
	logic        source_sop;
	logic        source_eop;
	logic        mode;
	logic [31:0] lfsr;
	int          error_count;
	int          word_count;
	int          read_count;
	int          pending;
	int          f;

	eee_imgproc #(
		.IMAGE_W       (IMAGE_W),
		.IMAGE_H       (IMAGE_H),
		.MSG_INTERVAL  (MSG_INTERVAL),
		.MSG_BUF_DEPTH (MSG_BUF_DEPTH)
	) i_dut (.*);

	imgproc_checker #(
		.IMAGE_W       (IMAGE_W),
		.IMAGE_H       (IMAGE_H),
		.MSG_INTERVAL  (MSG_INTERVAL),
		.MSG_BUF_DEPTH (MSG_BUF_DEPTH)
	) i_checker (.*);

	bind eee_imgproc imgproc_properties #(.MSG_BUF_DEPTH(MSG_BUF_DEPTH)) i_props (
		.clk          (clk),
		.reset_n      (reset_n),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_data  (source_data),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.msg_used     (msg_used)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
		source_ready = lfsr_bits(2) != 0;    // Sink stalls about a quarter of the time
	endtask

	task automatic send_word(input logic [23:0] data, input logic sop, input logic eop);
		logic done;
		done = 1'b0;
		while (lfsr_bits(3) == 0) begin
			sink_valid = 1'b0;
			next_cycle();
		end
		sink_data  = data;
		sink_sop   = sop;
		sink_eop   = eop;
		sink_valid = 1'b1;
		while (!done) begin
			@(negedge clk);
			done = sink_ready;
			next_cycle();
		end
		sink_valid = 1'b0;
	endtask

	task automatic send_video_frame(input int density);
		logic [23:0] pix;
		int          thr;
		int          i;
		thr = density * density * 2;    // Out of 128
		send_word(24'(lfsr_bits(20) << 4), 1'b1, 1'b0);
		for (i = 0; i < IMAGE_W * IMAGE_H; i++) begin
			pix     = 24'(lfsr_bits(24));
			pix[23] = 1'b0;
			if (lfsr_bits(7) < thr) begin
				pix = pix | 24'h808080;
			end
			send_word(pix, 1'b0, i == IMAGE_W * IMAGE_H - 1);
		end
	endtask

	task automatic send_other_packet();
		int i;
		send_word(24'(lfsr_bits(20) << 4) | 24'h1, 1'b1, 1'b0);
		for (i = 0; i < 6; i++) begin
			send_word(24'(lfsr_bits(24)), 1'b0, i == 5);
		end
	endtask

	task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
		s_chipselect = 1'b1;
		s_write      = 1'b1;
		s_address    = addr;
		s_writedata  = data;
		next_cycle();
		s_chipselect = 1'b0;
		s_write      = 1'b0;
	endtask

	task automatic read_reg(input logic [2:0] addr, input int cycles);
		s_chipselect = 1'b1;
		s_read       = 1'b1;
		s_address    = addr;
		repeat (cycles) next_cycle();
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		next_cycle();
	endtask

	// Message words land on the three cycles after the frame end
	task automatic wait_drain();
		while (pending != 0) begin
			next_cycle();
		end
		repeat (4) next_cycle();
	endtask

	task automatic register_phase();
		logic flush_first;
		flush_first = lfsr_bits(1) != 0;
		write_reg(imgproc_pkg::ADDR_BBCOL, {8'(lfsr_bits(8)), 24'(lfsr_bits(24))});
		read_reg(imgproc_pkg::ADDR_ID, 1);
		read_reg(imgproc_pkg::ADDR_BBCOL, 1);
		read_reg(imgproc_pkg::ADDR_STATUS, 1);
		if (flush_first) begin
			write_reg(imgproc_pkg::ADDR_STATUS, lfsr_bits(8) | 32'h10);
			read_reg(imgproc_pkg::ADDR_STATUS, 1);
		end
		read_reg(imgproc_pkg::ADDR_MSG, 2);    // Held strobe, single pop
		repeat (3) read_reg(imgproc_pkg::ADDR_MSG, 1);
		if (!flush_first) begin
			write_reg(imgproc_pkg::ADDR_STATUS, lfsr_bits(8) | 32'h10);
			read_reg(imgproc_pkg::ADDR_STATUS, 1);
			read_reg(imgproc_pkg::ADDR_MSG, 1);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		lfsr         = 32'h3a75_f4a1;
		reset_n      = 1'b0;
		s_chipselect = 1'b0;
		s_read       = 1'b0;
		s_write      = 1'b0;
		s_address    = '0;
		s_writedata  = '0;
		sink_data    = '0;
		sink_valid   = 1'b0;
		sink_sop     = 1'b0;
		sink_eop     = 1'b0;
		source_ready = 1'b0;
		mode         = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset_n = 1'b1;
		for (f = 0; f < NUM_FRAMES; f++) begin
			mode = (f < 2) ? 1'b1 : (lfsr_bits(1) != 0);    // First two show default colour
			if (lfsr_bits(2) == 0) begin
				send_other_packet();
			end
			send_video_frame(int'(lfsr_bits(2)));
			wait_drain();
			if (f != 0) begin
				register_phase();
			end
		end
		wait_drain();
		$display("%0d stream words and %0d register reads checked, %0d errors",
			word_count, read_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, stream or register traffic stalled",
			TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* compile.f */
rtl/imgproc_pkg.sv
rtl/stream_reg.sv
rtl/frame_scanner.sv
rtl/pixel_overlay.sv
rtl/msg_writer.sv
rtl/msg_fifo.sv
rtl/reg_port.sv
rtl/eee_imgproc.sv
sim/imgproc_properties.sv
sim/imgproc_checker.sv
sim/tb_imgproc.sv

/* Makefile */
TOP = tb_imgproc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
